/* Bender.yml */
package:
  name: fpAddSub

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fpAddSubPkg.sv
      - verilog/fpUnpack.sv
      - verilog/fpAlign.sv
      - verilog/fpMantAdd.sv
      - verilog/fpNormalize.sv
      - verilog/fpRoundPack.sv
      - verilog/fpAddSub.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/fpAddSub_props.sv
      - test/fpAddSubTb.sv

/* fpAddSub.f */
+incdir+verilog
verilog/fpAddSubPkg.sv
verilog/fpUnpack.sv
verilog/fpAlign.sv
verilog/fpMantAdd.sv
verilog/fpNormalize.sv
verilog/fpRoundPack.sv
verilog/fpAddSub.sv
test/fpAddSub_props.sv
test/fpAddSubTb.sv

/* test/fpAddSubTb.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpAddSubTb;
	import fpAddSubPkg::*;

	localparam int numRandom = 280;
	// Reset + ~300 strobes + short gaps + drain comes to about 400 cycles
	localparam int cycleLimit = 1000;

	logic clk;
	logic rst;
	logic inValid;
	fpWord a;
	fpWord b;
	logic operation;
	logic outValid;
	fpWord result;
	fpFlags flags;

	int seed = 32'h5c13;
	int issued = 0;
	int completed = 0;
	int cycles = 0;
	int otherErrors = 0;

	fpAddSub dut (.clk(clk), .rst(rst), .inValid(inValid), .a(a), .b(b),
		.operation(operation), .outValid(outValid), .result(result), .flags(flags));

	// Checker with the reference model rides on every fpAddSub
	bind fpAddSub fpAddSub_props props (.clk(clk), .rst(rst), .inValid(inValid),
		.a(a), .b(b), .operation(operation), .outValid(outValid), .result(result),
		.flags(flags));

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (!rst && outValid)
			completed++; // Mid-cycle, outputs settled
	end

	// One strobe, 1 ns after the edge
	task automatic issue(input fpWord x, input fpWord y, input logic op);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		a = x;
		b = y;
		operation = op;
		issued++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			inValid = 1'b0;
		end
	endtask

	// Normal operands, mixed signs, both operations
	task automatic randomOp();
		int expA;
		int expB;
		fpWord x;
		fpWord y;
		expA = 1 + {$random(seed)} % 30;
		if ({$random(seed)} % 4 == 0)
			expB = expA; // Same exponent, deep cancellation possible
		else
			expB = 1 + {$random(seed)} % 30; // Often more than 14 apart
		x = {1'($random(seed)), 5'(expA), 10'($random(seed))};
		y = {1'($random(seed)), 5'(expB), 10'($random(seed))};
		issue(x, y, 1'($random(seed)));
	endtask

	initial begin
		int total;
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		operation = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		idle(2);

		issue(16'h3C00, 16'h3C00, 1'b1); // x - x
		issue(16'h5A3B, 16'hDA3B, 1'b0); // x + (-x)
		issue(16'hC123, 16'hC123, 1'b1);

		issue(16'h7E01, 16'h3C00, 1'b0); // NaN operand
		issue(16'h3C00, 16'hFD00, 1'b1);
		issue(16'h7C00, 16'h7C00, 1'b1); // inf - inf
		issue(16'h7C00, 16'hFC00, 1'b0);
		issue(16'h7C00, 16'h3C00, 1'b0); // Infinity passes
		issue(16'hFC00, 16'h4000, 1'b1);
		issue(16'h3C00, 16'h7C00, 1'b1); // Gives -inf
		idle(1);

		issue(16'h7BFF, 16'h7BFF, 1'b0); // Max + max
		issue(16'hFBFF, 16'h7800, 1'b1);
		issue(16'h0401, 16'h0400, 1'b1); // One ulp below normal range
		issue(16'h8401, 16'h0400, 1'b0); // Negative tiny result
		issue(16'h0800, 16'h07FF, 1'b1);
		idle(3);

		for (int i = 0; i < numRandom; i++) begin
			randomOp();
			if ({$random(seed)} % 8 == 0)
				idle(1 + {$random(seed)} % 3);
		end
		idle(`FP_LATENCY + 2); // Drain the pipeline

		if (completed != issued) begin
			otherErrors++;
			$display("CHECK FAILED strobeCount expected %0d actual %0d", issued, completed);
		end
		total = dut.props.errorCount + otherErrors;
		$display("Operations %0d, outputs %0d, assertion errors %0d, other errors %0d",
			issued, completed, dut.props.errorCount, otherErrors);
		if (total == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* test/fpAddSub_props.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpAddSub_props (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fpAddSubPkg::fpWord a,
	input fpAddSubPkg::fpWord b,
	input logic operation,
	input logic outValid,
	input fpAddSubPkg::fpWord result,
	input fpAddSubPkg::fpFlags flags
);
	import fpAddSubPkg::*;

	int errorCount = 0; // Read by the testbench at the end

	function automatic real pow2(input int e);
		real p;
		p = 1.0;
		for (int i = 0; i < e; i++)
			p = p * 2.0;
		for (int i = 0; i > e; i--)
			p = p / 2.0;
		return p;
	endfunction

	// Exponent zero reads as zero since subnormals are flushed
	function automatic real decode(input fpWord w);
		real v;
		v = 0.0;
		if (w[14:10] != 5'd0)
			v = (1024.0 + w[9:0]) * pow2(int'(w[14:10]) - 25); // Bias plus mantissa width
		return w[15] ? -v : v;
	endfunction

	// Expected {flags, result} from the exact sum in real arithmetic
	function automatic logic [19:0] modelResult(input fpWord x, input fpWord y, input logic op);
		logic signY;
		logic nanX, nanY, infX, infY;
		logic neg;
		real sum, mag, scaled, frac;
		int e, whole, biased;
		signY = y[15] ^ op;
		nanX = (x[14:10] == 5'h1f) && (x[9:0] != 10'd0);
		nanY = (y[14:10] == 5'h1f) && (y[9:0] != 10'd0);
		infX = (x[14:10] == 5'h1f) && (x[9:0] == 10'd0);
		infY = (y[14:10] == 5'h1f) && (y[9:0] == 10'd0);
		if (nanX || nanY || (infX && infY && (x[15] != signY)))
			return {4'b0010, 16'h7E00}; // Invalid only
		if (infX)
			return {4'b0000, x[15], 15'h7C00};
		if (infY)
			return {4'b0000, signY, 15'h7C00};
		sum = decode(x) + (op ? -decode(y) : decode(y)); // Exact in double
		if (sum == 0.0)
			return 20'h00000; // Cancellation gives +0
		neg = sum < 0.0;
		mag = neg ? -sum : sum;
		e = 0;
		while (mag >= pow2(e + 1))
			e++;
		while (mag < pow2(e))
			e--;
		scaled = mag / pow2(e - 10); // 1024 <= scaled < 2048
		whole = $rtoi(scaled);
		frac = scaled - whole;
		if (frac > 0.5 || (frac == 0.5 && whole % 2 == 1))
			whole++; // Round to nearest even
		if (whole == 2048) begin
			whole = 1024; // Rounding carried into the exponent
			e++;
		end
		biased = e + `FP_BIAS;
		if (biased >= 31)
			return {4'b1001, neg, 15'h7C00}; // Overflow and inexact
		if (biased < 1)
			return {4'b0101, neg, 15'h0000}; // Flushed with underflow and inexact
		return {3'b000, frac != 0.0, neg, 5'(biased), 10'(whole)};
	endfunction

	// Output strobe FP_LATENCY after each input strobe and never otherwise
	strobeTiming: assert property (@(posedge clk) disable iff (rst)
		##`FP_LATENCY outValid == $past(inValid, `FP_LATENCY))
	else begin
		errorCount++;
		$error("CHECK FAILED strobeTiming expected %b actual %b",
			$past(inValid, `FP_LATENCY), $sampled(outValid));
	end

	resetState: assert property (@(posedge clk)
		rst |=> !outValid && result == '0 && flags == '0)
	else begin
		errorCount++;
		$error("CHECK FAILED resetState expected %h actual %h",
			21'h0, $sampled({outValid, flags, result}));
	end

	// Flags nibble above the encoded result
	resultAndFlags: assert property (@(posedge clk) disable iff (rst)
		outValid |-> {flags, result} == modelResult($past(a, `FP_LATENCY),
			$past(b, `FP_LATENCY), $past(operation, `FP_LATENCY)))
	else begin
		errorCount++;
		$error("CHECK FAILED resultAndFlags expected %h actual %h",
			modelResult($past(a, `FP_LATENCY), $past(b, `FP_LATENCY),
				$past(operation, `FP_LATENCY)),
			$sampled({flags, result}));
	end

endmodule

/* verilog/fpAddSub.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpAddSub (
	input logic clk,
	input logic rst,
	input logic inValid, // One operation per strobe
	input fpAddSubPkg::fpWord a,
	input fpAddSubPkg::fpWord b,
	input logic operation, // 0 add, 1 subtract
	output logic outValid, // FP_LATENCY cycles after inValid
	output fpAddSubPkg::fpWord result,
	output fpAddSubPkg::fpFlags flags
);
	import fpAddSubPkg::*;

	logic stValid; // Unpack -> align
	unpackedOp stOp;
	logic alValid; // Align -> add
	alignedOp alOp;
	logic smValid; // Add -> normalize
	sumOp smOp;
	logic nmValid; // Normalize -> round
	normOp nmOp;

	// Classify, swap, compute shift
	fpUnpack unpack (.clk(clk), .rst(rst), .inValid(inValid), .a(a), .b(b),
		.operation(operation), .stValid(stValid), .stOut(stOp));

	// Right shift with sticky
	fpAlign align (.clk(clk), .rst(rst), .stValid(stValid), .stIn(stOp),
		.alValid(alValid), .alOut(alOp));

	// Effective add or subtract
	fpMantAdd mantAdd (.clk(clk), .rst(rst), .alValid(alValid), .alIn(alOp),
		.smValid(smValid), .smOut(smOp));

	// Leading one, shift, exponent fix
	fpNormalize normalize (.clk(clk), .rst(rst), .smValid(smValid), .smIn(smOp),
		.nmValid(nmValid), .nmOut(nmOp));

	fpRoundPack roundPack (
		.clk(clk),
		.rst(rst),
		.nmValid(nmValid),
		.nmIn(nmOp),
		.outValid(outValid),
		.result(result),
		.flags(flags)
	); // RNE, overflow/flush, specials, flags

endmodule

/* verilog/fpRoundPack.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpRoundPack (
	input logic clk,
	input logic rst,
	input logic nmValid,
	input fpAddSubPkg::normOp nmIn,
	output logic outValid,
	output fpAddSubPkg::fpWord result, // Holds between strobes
	output fpAddSubPkg::fpFlags flags
);
	import fpAddSubPkg::*;

	logic lostBits; // Anything below the mantissa LSB
	logic roundUp;
	logic [`FP_MAN:0] roundSig; // Top bit is the rounding carry
	logic signed [6:0] finalExp;
	fpWord nextResult;
	fpFlags nextFlags;

	always_comb begin
		lostBits = nmIn.guard | nmIn.sticky;
		// Nearest, ties to even
		roundUp = nmIn.guard & (nmIn.sticky | nmIn.mant[0]);
		roundSig = {1'b0, nmIn.mant} + {{`FP_MAN{1'b0}}, roundUp};
		// All-ones mantissa rounding up bumps the exponent, mantissa wraps to zero
		finalExp = nmIn.normExp + $signed({6'b000000, roundSig[`FP_MAN]});

		nextResult = '0;
		nextFlags = '0;
		if (nmIn.special == nan) begin
			nextResult = {1'b0, {`FP_EXP{1'b1}}, 1'b1, {(`FP_MAN-1){1'b0}}}; // 7E00
			nextFlags.invalid = 1'b1;
		end else if (nmIn.special == infinity) begin
			nextResult = {nmIn.specialSign, {`FP_EXP{1'b1}}, {`FP_MAN{1'b0}}}; // Exact, no flags
		end else if (nmIn.zero) begin
			nextResult = {nmIn.sign, {(`FP_WIDTH-1){1'b0}}};
		end else if (finalExp >= 7'sd31) begin
			// Exponent field would reach the reserved all-ones code
			nextResult = {nmIn.sign, {`FP_EXP{1'b1}}, {`FP_MAN{1'b0}}};
			nextFlags.overflow = 1'b1;
			nextFlags.inexact = 1'b1;
		end else if (finalExp < 7'sd1) begin
			nextResult = {nmIn.sign, {(`FP_WIDTH-1){1'b0}}}; // Flush to signed zero
			nextFlags.underflow = 1'b1;
			nextFlags.inexact = 1'b1;
		end else begin
			nextResult = {nmIn.sign, finalExp[`FP_EXP-1:0], roundSig[`FP_MAN-1:0]};
			nextFlags.inexact = lostBits;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			outValid <= nmValid;
			if (nmValid) begin
				result <= nextResult;
				flags <= nextFlags;
			end
		end
	end

endmodule

/* verilog/fpNormalize.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpNormalize (
	input logic clk,
	input logic rst,
	input logic smValid,
	input fpAddSubPkg::sumOp smIn,
	output logic nmValid,
	output fpAddSubPkg::normOp nmOut
);
	import fpAddSubPkg::*;

	logic [3:0] lzCount; // Zeros above the leading one, below carry
	logic [`FP_MAN+`FP_GRS:0] leftSig; // Sum without carry, shifted up
	logic signed [6:0] expIn;
	normOp next;

	always_comb begin
		// Priority search, highest set bit wins
		lzCount = 4'd0;
		for (int i = 0; i <= `FP_MAN + `FP_GRS; i++) begin
			if (smIn.sum[i])
				lzCount = 4'(`FP_MAN + `FP_GRS - i);
		end
		leftSig = smIn.sum[`FP_MAN+`FP_GRS:0] << lzCount;
		expIn = $signed({2'b00, smIn.commonExp});

		if (smIn.sum[`FP_MAN+`FP_GRS+1]) begin
			// Carry out, shift right by one
			next.mant = smIn.sum[`FP_MAN+`FP_GRS:`FP_GRS+1];
			next.guard = smIn.sum[`FP_GRS];
			next.sticky = |smIn.sum[`FP_GRS-1:0];
			next.normExp = expIn + 7'sd1;
		end else begin
			// Large shifts only after near cancellation, sticky is clear then
			next.mant = leftSig[`FP_MAN+`FP_GRS-1:`FP_GRS];
			next.guard = leftSig[`FP_GRS-1];
			next.sticky = |leftSig[`FP_GRS-2:0];
			next.normExp = expIn - $signed({3'b000, lzCount}); // May go below 1
		end

		next.sign = smIn.sign;
		next.zero = smIn.zero;
		next.special = smIn.special;
		next.specialSign = smIn.specialSign;
	end

	always_ff @(posedge clk) begin
		if (rst)
			nmValid <= 1'b0;
		else
			nmValid <= smValid;
	end

	always_ff @(posedge clk) begin
		if (smValid)
			nmOut <= next;
	end

endmodule

/* verilog/fpMantAdd.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpMantAdd (
	input logic clk,
	input logic rst,
	input logic alValid,
	input fpAddSubPkg::alignedOp alIn,
	output logic smValid,
	output fpAddSubPkg::sumOp smOut
);
	import fpAddSubPkg::*;

	logic [`FP_MAN+`FP_GRS+1:0] bigWide; // Leading zero leaves room for carry
	logic [`FP_MAN+`FP_GRS+1:0] smallWide;
	logic [`FP_MAN+`FP_GRS+1:0] rawSum;
	sumOp next;

	always_comb begin
		bigWide = {1'b0, alIn.bigSig, {`FP_GRS{1'b0}}};
		smallWide = {1'b0, alIn.smallSig};
		// Ordered by magnitude, so the difference is never negative
		rawSum = alIn.effSub ? (bigWide - smallWide) : (bigWide + smallWide);

		next.sum = rawSum;
		next.commonExp = alIn.commonExp;
		next.zero = ~(|rawSum);
		next.sign = alIn.sign & (|rawSum); // Cancellation gives +0
		next.special = alIn.special;
		next.specialSign = alIn.specialSign;
	end

	always_ff @(posedge clk) begin
		if (rst)
			smValid <= 1'b0;
		else
			smValid <= alValid;
		if (alValid)
			smOut <= next;
	end

endmodule

/* verilog/fpAlign.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpAlign (
	input logic clk,
	input logic rst,
	input logic stValid,
	input fpAddSubPkg::unpackedOp stIn,
	output logic alValid,
	output fpAddSubPkg::alignedOp alOut
);
	import fpAddSubPkg::*;

	logic [`FP_MAN+`FP_GRS:0] wideSig; // Small significand plus empty GRS
	logic [`FP_MAN+`FP_GRS:0] shiftedSig;
	logic [`FP_MAN+`FP_GRS:0] lostMask; // Ones where bits fall off
	logic sticky;
	alignedOp next;

	always_comb begin
		wideSig = {stIn.smallSig, {`FP_GRS{1'b0}}};
		shiftedSig = wideSig >> stIn.shift; // Barrel shifter, 0..14
		lostMask = ~({(`FP_MAN+`FP_GRS+1){1'b1}} << stIn.shift);
		sticky = |(wideSig & lostMask);

		next.bigSig = stIn.bigSig;
		// Anything shifted out is folded into the LSB
		next.smallSig = {shiftedSig[`FP_MAN+`FP_GRS:1], shiftedSig[0] | sticky};
		next.commonExp = stIn.commonExp;
		next.shift = stIn.shift;
		next.sign = stIn.sign;
		next.effSub = stIn.effSub;
		next.special = stIn.special;
		next.specialSign = stIn.specialSign;
	end

	always_ff @(posedge clk) begin
		if (rst)
			alValid <= 1'b0;
		else
			alValid <= stValid;
	end

	always_ff @(posedge clk) begin
		if (stValid)
			alOut <= next;
	end

endmodule

/* verilog/fpUnpack.sv */
`timescale 1ns/100ps
`include "fpAddSub_defs.svh"

module fpUnpack (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fpAddSubPkg::fpWord a,
	input fpAddSubPkg::fpWord b,
	input logic operation,
	output logic stValid,
	output fpAddSubPkg::unpackedOp stOut
);
	import fpAddSubPkg::*;

	logic [`FP_EXP-1:0] expA, expB;
	logic signA, signB; // signB already flipped for subtract
	logic nanA, nanB, infA, infB;
	logic [`FP_MAN:0] sigA, sigB; // Zero when exponent is zero
	logic [`FP_EXP+`FP_MAN-1:0] magA, magB;
	logic aBig; // A has the larger or equal magnitude
	logic [`FP_EXP-1:0] expDiff;
	unpackedOp next;

	always_comb begin
		expA = a[`FP_WIDTH-2:`FP_MAN];
		expB = b[`FP_WIDTH-2:`FP_MAN];
		signA = a[`FP_WIDTH-1];
		signB = b[`FP_WIDTH-1] ^ operation; // a - b == a + (-b)
		nanA = (&expA) & (|a[`FP_MAN-1:0]);
		nanB = (&expB) & (|b[`FP_MAN-1:0]);
		infA = (&expA) & ~(|a[`FP_MAN-1:0]);
		infB = (&expB) & ~(|b[`FP_MAN-1:0]);
		// Exponent zero reads as zero, subnormals flushed
		sigA = (expA == '0) ? '0 : {1'b1, a[`FP_MAN-1:0]};
		sigB = (expB == '0) ? '0 : {1'b1, b[`FP_MAN-1:0]};
		magA = (expA == '0) ? '0 : a[`FP_WIDTH-2:0];
		magB = (expB == '0) ? '0 : b[`FP_WIDTH-2:0];
		aBig = magA >= magB; // Exponent then mantissa in one compare
		expDiff = aBig ? (expA - expB) : (expB - expA);

		next.bigSig = aBig ? sigA : sigB;
		next.smallSig = aBig ? sigB : sigA;
		next.commonExp = aBig ? expA : expB;
		// Past 14 every bit lands in sticky
		next.shift = (expDiff > 5'd14) ? 4'd14 : expDiff[3:0];
		next.sign = aBig ? signA : signB;
		next.effSub = signA ^ signB;

		next.specialSign = 1'b0;
		if (nanA | nanB | (infA & infB & (signA ^ signB))) begin
			next.special = nan; // Includes inf - inf
		end else if (infA) begin
			next.special = infinity;
			next.specialSign = signA;
		end else if (infB) begin
			next.special = infinity;
			next.specialSign = signB;
		end else begin
			next.special = none;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			stValid <= 1'b0;
		else
			stValid <= inValid;
		if (inValid)
			stOut <= next; // Payload only moves with a strobe
	end

endmodule

/* verilog/fpAddSubPkg.sv */
`include "fpAddSub_defs.svh"

package fpAddSubPkg;

	typedef logic [`FP_WIDTH-1:0] fpWord; // One encoded binary16 value

	// IEEE exception flags, no divide-by-zero for add/sub
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} fpFlags;

	// Result forced by the last stage
	typedef enum logic [1:0] {
		none,
		nan,
		infinity
	} specialKind;

	// Stage 1 to stage 2
	typedef struct packed {
		logic [`FP_MAN:0] bigSig; // Larger significand incl. hidden bit
		logic [`FP_MAN:0] smallSig; // Smaller significand incl. hidden bit
		logic [`FP_EXP-1:0] commonExp; // Exponent of larger operand
		logic [3:0] shift; // Alignment distance, saturated at 14
		logic sign; // Sign of larger operand
		logic effSub; // Signs differ after applying operation
		specialKind special;
		logic specialSign;
	} unpackedOp;

	// Stage 2 to stage 3
	typedef struct packed {
		logic [`FP_MAN:0] bigSig;
		logic [`FP_MAN+`FP_GRS:0] smallSig; // Shifted, GRS bits at the bottom
		logic [`FP_EXP-1:0] commonExp;
		logic [3:0] shift;
		logic sign;
		logic effSub;
		specialKind special;
		logic specialSign;
	} alignedOp;

	// Stage 3 to stage 4
	typedef struct packed {
		logic [`FP_MAN+`FP_GRS+1:0] sum; // Carry, hidden, mantissa, GRS
		logic [`FP_EXP-1:0] commonExp;
		logic sign;
		logic zero; // Sum is exactly zero
		specialKind special;
		logic specialSign;
	} sumOp;

	// Stage 4 to stage 5
	typedef struct packed {
		logic [`FP_MAN-1:0] mant; // Normalized, hidden bit dropped
		logic guard;
		logic sticky; // Round and sticky merged
		logic signed [6:0] normExp; // May leave the 1..30 range
		logic sign;
		logic zero;
		specialKind special;
		logic specialSign;
	} normOp;

endpackage

/* verilog/fpAddSub_defs.svh */
`ifndef FP_ADD_SUB_DEFS_SVH
`define FP_ADD_SUB_DEFS_SVH

// binary16 layout

`define FP_WIDTH 16 // Sign + exponent + mantissa

`define FP_EXP 5 // Exponent field

`define FP_MAN 10 // Stored mantissa, hidden bit not counted

`define FP_BIAS 15 // Exponent bias

// Guard, round and sticky bits kept below the significand
// while the smaller operand is aligned
`define FP_GRS 3

// Input strobe to output strobe, one cycle per stage
`define FP_LATENCY 5

`endif
